// ==== all.f ====
+incdir+src
src/cp0_pkg.sv
src/cp0_timer.sv
src/cp0_tlb_ctrl.sv
src/cp0_regs.sv
src/cp0_tlb.sv
src/cp0_top.sv
sim/cp0_tb.sv

// ==== sim/cp0_tb.sv ====
`timescale 1ns/1ns
`include "cp0_defines.svh"

module cp0_tb;

	// Upper bound on the run summed over all tests
	localparam int RUN_CYCLES = 8 + 39 * 5 + 20 * 30 + 80 + 19 * 20 + 4 * 14 + 200 + 9 * 14;

	logic                 clk = 1'b0;
	logic                 rst_i;
	cp0_pkg::cp0_wr_t     cp0_wr_i;
	logic [4:0]           raddr_i;
	logic [31:0]          rdata_o;
	cp0_pkg::cp0_except_t except_i;
	logic [5:0]           int_i;
	cp0_pkg::tlb_op_e     tlb_op_i;
	logic                 tlb_busy_o;
	cp0_pkg::xlat_req_t   inst_req_i;
	cp0_pkg::xlat_resp_t  inst_resp_o;
	cp0_pkg::xlat_req_t   data_req_i;
	cp0_pkg::xlat_resp_t  data_resp_o;
	logic                 int_pending_o;
	logic                 timer_int_o;

	int errors = 0;
	int cycles = 0;
	cp0_pkg::tlb_entry_t ref_tlb [`TLB_ENTRIES];

	cp0_top u_cp0_top (.*);

	always #2 clk = ~clk;

	// Clock edges since reset release, for the Random model
	always @(posedge clk) begin
		if (!rst_i) begin
			cycles <= cycles + 1;
		end
	end

	// Expected read value one cycle after a software write of d
	function automatic logic [31:0] read_ref(input logic [4:0] a, input logic [31:0] d);
		case (a)
			`CP0_INDEX: return d & 32'h0000_000F;
			`CP0_RANDOM: return (`TLB_ENTRIES - 1) - (cycles % `TLB_ENTRIES);
			`CP0_ENTRYLO0, `CP0_ENTRYLO1: return d & 32'h03FF_FFFF;
			`CP0_ENTRYHI: return d & 32'hFFFF_E0FF;
			`CP0_CAUSE: return d & 32'h0080_0300;
			`CP0_PRID: return `PRID_VALUE;
			`CP0_CONFIG: return `CONFIG_RESET;
			`CP0_BADVADDR: return 32'h0;
			// Count reads back unchanged in the first cycle
			default: return d;
		endcase
	endfunction

	function automatic logic pend_ref(input logic [31:0] status, input logic [7:0] ip);
		return status[0] && !status[1] && |(ip & status[15:8]);
	endfunction

	function automatic logic loads_badv(input logic [4:0] code);
		return code inside {`EXC_MOD, `EXC_TLBL, `EXC_TLBS, `EXC_ADEL, `EXC_ADES};
	endfunction

	function automatic cp0_pkg::xlat_resp_t xlat_ref(input cp0_pkg::xlat_req_t q,
		input logic [7:0] asid);
		cp0_pkg::xlat_resp_t r;
		cp0_pkg::tlb_entry_t e;
		logic hit;
		logic [19:0] pfn;
		logic [2:0] c;
		logic d;
		logic v;
		r = '0;
		e = '0;
		hit = 1'b0;
		if (q.vaddr[31:30] == 2'b10) begin
			r.paddr = {3'b000, q.vaddr[28:0]};
			r.cached = !q.vaddr[29];
			return r;
		end
		foreach (ref_tlb[i]) begin
			if (ref_tlb[i].vpn2 == q.vaddr[31:13] &&
				(ref_tlb[i].g || ref_tlb[i].asid == asid)) begin
				hit = 1'b1;
				e = ref_tlb[i];
			end
		end
		pfn = q.vaddr[12] ? e.pfn1 : e.pfn0;
		c = q.vaddr[12] ? e.c1 : e.c0;
		d = q.vaddr[12] ? e.d1 : e.d0;
		v = q.vaddr[12] ? e.v1 : e.v0;
		r.paddr = {pfn, q.vaddr[11:0]};
		r.miss = !hit;
		r.invalid = hit && !v;
		r.modified = hit && v && q.wen && !d;
		r.cached = hit && c == 3'd3;
		return r;
	endfunction

	function automatic cp0_pkg::tlb_entry_t rand_entry(input logic [3:0] tag,
		input logic [1:0] top);
		cp0_pkg::tlb_entry_t e;
		e.pfn0 = 20'($urandom);
		e.c0 = 3'($urandom);
		e.d0 = 1'($urandom);
		e.pfn1 = 20'($urandom);
		e.c1 = 3'($urandom);
		e.d1 = 1'($urandom);
		// Tag field keeps VPN2 unique
		e.vpn2 = {top, tag, 13'($urandom)};
		e.asid = 8'($urandom_range(1, 2));
		e.g = ($urandom % 4) == 0;
		e.v0 = ($urandom % 4) != 0;
		e.v1 = ($urandom % 4) != 0;
		return e;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_xlat(input string name, input cp0_pkg::xlat_resp_t got,
		input cp0_pkg::xlat_resp_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_int(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
		@(posedge clk) cp0_wr_i <= '{1'b1, a, d};
		@(posedge clk) cp0_wr_i <= '0;
	endtask

	task automatic read_check(input string name, input logic [4:0] a, input logic [31:0] exp);
		@(posedge clk) raddr_i <= a;
		@(negedge clk) check_word(name, rdata_o, exp);
	endtask

	// Samples Random in the pulse cycle and checks for a single busy cycle
	task automatic tlb_op(input cp0_pkg::tlb_op_e op, output logic [3:0] rnd);
		@(posedge clk);
		tlb_op_i <= op;
		raddr_i <= `CP0_RANDOM;
		@(negedge clk) rnd = rdata_o[3:0];
		@(posedge clk) tlb_op_i <= cp0_pkg::TLB_NONE;
		@(negedge clk);
		if (!tlb_busy_o) begin
			errors++;
			$display("TLB busy flag was low in the cycle after the operation pulse");
		end
		@(negedge clk);
		if (tlb_busy_o) begin
			errors++;
			$display("TLB busy flag stayed high for more than one cycle");
		end
	endtask

	task automatic tlb_load(input cp0_pkg::tlb_entry_t e, input logic [3:0] idx,
		input cp0_pkg::tlb_op_e op, output logic [3:0] rnd);
		write_reg(`CP0_ENTRYLO0, {6'b0, e.pfn0, e.c0, e.d0, e.v0, e.g});
		write_reg(`CP0_ENTRYLO1, {6'b0, e.pfn1, e.c1, e.d1, e.v1, e.g});
		write_reg(`CP0_ENTRYHI, {e.vpn2, 5'b0, e.asid});
		write_reg(`CP0_INDEX, {28'b0, idx});
		tlb_op(op, rnd);
	endtask

	task automatic commit(input logic eret, input logic [4:0] code, input logic [31:0] pc,
		input logic ds, input logic [31:0] bva);
		@(posedge clk) except_i <= '{1'b1, eret, code, pc, ds, bva};
		@(posedge clk) except_i <= '0;
	endtask

	initial begin
		#((RUN_CYCLES + 1000) * 4);
		$display("Watchdog expired before the tests completed");
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [4:0] regs [13];
		logic [4:0] codes [10];
		logic [4:0] nest_code;
		logic [31:0] d;
		logic [31:0] pc;
		logic [31:0] bva;
		logic [31:0] epc;
		logic [31:0] badv;
		logic [31:0] t;
		logic [3:0] r;
		logic [3:0] j;
		logic bd;
		logic exp_t;
		cp0_pkg::tlb_entry_t e;
		cp0_pkg::xlat_req_t qi;
		cp0_pkg::xlat_req_t qd;
		regs = '{`CP0_INDEX, `CP0_RANDOM, `CP0_ENTRYLO0, `CP0_ENTRYLO1, `CP0_ENTRYHI,
			`CP0_COUNT, `CP0_COMPARE, `CP0_STATUS, `CP0_CAUSE, `CP0_EPC, `CP0_PRID,
			`CP0_CONFIG, `CP0_BADVADDR};
		codes = '{`EXC_INT, `EXC_MOD, `EXC_TLBL, `EXC_TLBS, `EXC_ADEL, `EXC_ADES, `EXC_SYS,
			`EXC_BP, `EXC_RI, `EXC_OV};
		void'($urandom(51));
		rst_i = 1'b1;
		cp0_wr_i = '0;
		raddr_i = '0;
		except_i = '0;
		int_i = '0;
		tlb_op_i = cp0_pkg::TLB_NONE;
		inst_req_i = '0;
		data_req_i = '0;
		repeat (8) @(posedge clk);
		rst_i <= 1'b0;

		// Register access, read in the cycle right after the write
		repeat (3) begin
			foreach (regs[i]) begin
				d = $urandom;
				@(posedge clk) cp0_wr_i <= '{1'b1, regs[i], d};
				@(posedge clk);
				cp0_wr_i <= '0;
				raddr_i <= regs[i];
				@(negedge clk) check_word("rdata_o", rdata_o, read_ref(regs[i], d));
			end
		end

		// Each exception with EXL clear and again nested under another code
		write_reg(`CP0_COMPARE, 32'h0);
		write_reg(`CP0_CAUSE, 32'h0);
		badv = 32'h0;
		foreach (codes[i]) begin
			for (int ds = 0; ds < 2; ds++) begin
				write_reg(`CP0_STATUS, `STATUS_RESET);
				pc = $urandom & 32'hFFFF_FFFC;
				bva = $urandom;
				commit(1'b0, codes[i], pc, ds[0], bva);
				epc = ds ? pc - 32'd4 : pc;
				bd = ds[0];
				if (loads_badv(codes[i])) badv = bva;
				nest_code = codes[(i + 1) % 10];
				bva = $urandom;
				commit(1'b0, nest_code, $urandom & 32'hFFFF_FFFC, !ds[0], bva);
				if (loads_badv(nest_code)) badv = bva;
				read_check("EPC", `CP0_EPC, epc);
				read_check("Cause", `CP0_CAUSE, {bd, 24'b0, nest_code, 2'b00});
				read_check("Status", `CP0_STATUS, `STATUS_RESET | 32'h2);
				read_check("BadVAddr", `CP0_BADVADDR, badv);
				commit(1'b1, 5'd0, 32'h0, 1'b0, 32'h0);
				read_check("Status after ERET", `CP0_STATUS, `STATUS_RESET);
			end
		end

		// Timer interrupt with IE and IM7 set
		write_reg(`CP0_STATUS, 32'h0000_8001);
		@(posedge clk) raddr_i <= `CP0_COUNT;
		@(negedge clk) t = rdata_o + 32'd12;
		@(posedge clk) cp0_wr_i <= '{1'b1, `CP0_COMPARE, t};
		@(posedge clk) cp0_wr_i <= '0;
		for (int m = 0; m < 20; m++) begin
			@(negedge clk);
			// Count is two ahead at m = 0 and meets Compare at m = 10
			exp_t = (m > 10);
			check_int("{timer_int_o,int_pending_o}", {timer_int_o, int_pending_o},
				{exp_t, pend_ref(32'h0000_8001, {exp_t, 7'b0})});
		end
		write_reg(`CP0_COMPARE, 32'h0);
		@(negedge clk) check_int("{timer_int_o,int_pending_o}",
			{timer_int_o, int_pending_o}, 2'b00);
		@(posedge clk) int_i <= 6'b000001;
		write_reg(`CP0_STATUS, 32'h0000_0401);
		@(negedge clk) check_int("{timer_int_o,int_pending_o}", {timer_int_o, int_pending_o},
			{1'b0, pend_ref(32'h0000_0401, 8'h04)});
		write_reg(`CP0_STATUS, 32'h0000_0400);
		@(negedge clk) check_int("{timer_int_o,int_pending_o}",
			{timer_int_o, int_pending_o}, 2'b00);
		@(posedge clk) int_i <= '0;

		// TLBWI into every slot and TLBR back
		for (int i = 0; i < `TLB_ENTRIES; i++) begin
			e = rand_entry(4'(i), ($urandom % 2) ? 2'b11 : 2'b00);
			tlb_load(e, 4'(i), cp0_pkg::TLB_WI, r);
			ref_tlb[i] = e;
		end
		repeat (4) begin
			j = 4'($urandom);
			write_reg(`CP0_INDEX, {28'b0, j});
			tlb_op(cp0_pkg::TLB_R, r);
			read_check("EntryHi", `CP0_ENTRYHI, {ref_tlb[j].vpn2, 5'b0, ref_tlb[j].asid});
			read_check("EntryLo0", `CP0_ENTRYLO0, {6'b0, ref_tlb[j].pfn0, ref_tlb[j].c0,
				ref_tlb[j].d0, ref_tlb[j].v0, ref_tlb[j].g});
			read_check("EntryLo1", `CP0_ENTRYLO1, {6'b0, ref_tlb[j].pfn1, ref_tlb[j].c1,
				ref_tlb[j].d1, ref_tlb[j].v1, ref_tlb[j].g});
		end
		for (int k = 0; k < 3; k++) begin
			e = rand_entry(4'(k), 2'b01);
			tlb_load(e, 4'h0, cp0_pkg::TLB_WR, r);
			ref_tlb[r] = e;
			tlb_op(cp0_pkg::TLB_P, j);
			read_check("Index after TLBWR", `CP0_INDEX, {28'b0, r});
		end

		// Translation on both ports with ASID 1
		write_reg(`CP0_ENTRYHI, 32'h0000_0001);
		repeat (100) begin
			qi = {$urandom, 2'b10};
			qd = {$urandom, 1'b0, 1'($urandom)};
			qd.ren = !qd.wen;
			case ($urandom % 3)
				0: qi.vaddr = {2'b10, 30'($urandom)};
				1: qi.vaddr = {ref_tlb[$urandom % 16].vpn2, 13'($urandom)};
				default: begin
				end
			endcase
			if ($urandom % 3 != 0) qd.vaddr = {ref_tlb[$urandom % 16].vpn2, 13'($urandom)};
			@(posedge clk);
			inst_req_i <= qi;
			data_req_i <= qd;
			@(negedge clk);
			check_xlat("inst_resp_o", inst_resp_o, xlat_ref(qi, 8'd1));
			check_xlat("data_resp_o", data_resp_o, xlat_ref(qd, 8'd1));
		end

		// Probe hits and a miss that keeps the index
		repeat (8) begin
			j = 4'($urandom);
			write_reg(`CP0_ENTRYHI, {ref_tlb[j].vpn2, 5'b0, ref_tlb[j].asid});
			tlb_op(cp0_pkg::TLB_P, r);
			read_check("Index after hit", `CP0_INDEX, {28'b0, j});
		end
		write_reg(`CP0_ENTRYHI, {2'b01, 17'h1FFFF, 5'b0, 8'd1});
		tlb_op(cp0_pkg::TLB_P, r);
		read_check("Index after miss", `CP0_INDEX, {1'b1, 27'b0, j});

		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== src/cp0_top.sv ====
`timescale 1ns/1ns
`include "cp0_defines.svh"

module cp0_top (
	input  logic                 clk,
	input  logic                 rst_i,
	input  cp0_pkg::cp0_wr_t     cp0_wr_i,
	input  logic [4:0]           raddr_i,
	output logic [31:0]          rdata_o,
	input  cp0_pkg::cp0_except_t except_i,
	input  logic [5:0]           int_i,
	input  cp0_pkg::tlb_op_e     tlb_op_i,
	output logic                 tlb_busy_o,
	input  cp0_pkg::xlat_req_t   inst_req_i,
	output cp0_pkg::xlat_resp_t  inst_resp_o,
	input  cp0_pkg::xlat_req_t   data_req_i,
	output cp0_pkg::xlat_resp_t  data_resp_o,
	output logic                 int_pending_o,
	output logic                 timer_int_o
);

	cp0_pkg::cp0_wr_t      count_wr;
	logic [31:0]           count;
	logic [31:0]           compare;
	logic [`TLB_IDX_W-1:0] random;
	logic [`TLB_IDX_W-1:0] index;
	logic [31:0]           entryhi;
	cp0_pkg::tlb_entry_t   wr_entry;
	cp0_pkg::tlb_entry_t   rd_entry;
	logic                  tlb_we;
	logic [`TLB_IDX_W-1:0] tlb_widx;
	logic [`TLB_IDX_W-1:0] tlb_ridx;
	logic                  probe;
	logic                  upd_index;
	logic                  upd_entry;
	logic                  probe_hit;
	logic [`TLB_IDX_W-1:0] probe_idx;

	cp0_timer u_cp0_timer (
		.clk         (clk),
		.rst_i       (rst_i),
		.count_wr_i  (count_wr),
		.count_o     (count),
		.compare_o   (compare),
		.random_o    (random),
		.timer_int_o (timer_int_o)
	);

	cp0_tlb_ctrl u_cp0_tlb_ctrl (
		.clk         (clk),
		.rst_i       (rst_i),
		.tlb_op_i    (tlb_op_i),
		.index_i     (index),
		.random_i    (random),
		.tlb_busy_o  (tlb_busy_o),
		.tlb_we_o    (tlb_we),
		.tlb_widx_o  (tlb_widx),
		.tlb_ridx_o  (tlb_ridx),
		.probe_o     (probe),
		.upd_index_o (upd_index),
		.upd_entry_o (upd_entry)
	);

	cp0_regs u_cp0_regs (
		.clk (clk), .rst_i (rst_i), .cp0_wr_i (cp0_wr_i), .raddr_i (raddr_i),
		.rdata_o (rdata_o), .except_i (except_i), .int_i (int_i),
		.timer_int_i (timer_int_o), .count_i (count), .compare_i (compare),
		.random_i (random), .count_wr_o (count_wr), .upd_index_i (upd_index),
		.upd_entry_i (upd_entry), .probe_hit_i (probe_hit), .probe_idx_i (probe_idx),
		.rd_entry_i (rd_entry), .index_o (index), .entryhi_o (entryhi),
		.wr_entry_o (wr_entry), .int_pending_o (int_pending_o)
	);

	cp0_tlb u_cp0_tlb (
		.clk (clk), .rst_i (rst_i), .we_i (tlb_we), .widx_i (tlb_widx),
		.wentry_i (wr_entry), .ridx_i (tlb_ridx), .rentry_o (rd_entry),
		.probe_i (probe), .entryhi_i (entryhi), .probe_hit_o (probe_hit),
		.probe_idx_o (probe_idx), .inst_req_i (inst_req_i), .inst_resp_o (inst_resp_o),
		.data_req_i (data_req_i), .data_resp_o (data_resp_o)
	);

endmodule

// ==== src/cp0_tlb.sv ====
`timescale 1ns/1ns
`include "cp0_defines.svh"

module cp0_tlb (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  we_i,
	input  logic [`TLB_IDX_W-1:0] widx_i,
	input  cp0_pkg::tlb_entry_t   wentry_i,
	input  logic [`TLB_IDX_W-1:0] ridx_i,
	output cp0_pkg::tlb_entry_t   rentry_o,
	input  logic                  probe_i,
	input  logic [31:0]           entryhi_i,
	output logic                  probe_hit_o,
	output logic [`TLB_IDX_W-1:0] probe_idx_o,
	input  cp0_pkg::xlat_req_t    inst_req_i,
	output cp0_pkg::xlat_resp_t   inst_resp_o,
	input  cp0_pkg::xlat_req_t    data_req_i,
	output cp0_pkg::xlat_resp_t   data_resp_o
);

	cp0_pkg::tlb_entry_t entries [`TLB_ENTRIES];
	logic [`TLB_ENTRIES-1:0] probe_vec;

	function automatic logic entry_match(input cp0_pkg::tlb_entry_t e, input logic [18:0] vpn2,
		input logic [7:0] asid);
		return (e.vpn2 == vpn2) && (e.g || e.asid == asid);
	endfunction

	function automatic cp0_pkg::xlat_resp_t translate(input cp0_pkg::xlat_req_t req,
		input logic [7:0] asid);
		cp0_pkg::xlat_resp_t resp;
		cp0_pkg::tlb_entry_t e;
		logic hit;
		logic [19:0] pfn;
		logic [2:0] c;
		logic d;
		logic v;
		resp = '0;
		e = '0;
		hit = 1'b0;
		// kseg0 and kseg1 bypass the TLB
		if (req.vaddr[31:30] == 2'b10) begin
			resp.paddr  = {3'b000, req.vaddr[28:0]};
			resp.cached = !req.vaddr[29];
			return resp;
		end
		for (int i = 0; i < `TLB_ENTRIES; i++) begin
			if (!hit && entry_match(entries[i], req.vaddr[31:13], asid)) begin
				hit = 1'b1;
				e = entries[i];
			end
		end
		// Bit 12 picks the odd page
		{pfn, c, d, v} = req.vaddr[12] ? {e.pfn1, e.c1, e.d1, e.v1} : {e.pfn0, e.c0, e.d0, e.v0};
		resp.paddr    = {pfn, req.vaddr[11:0]};
		resp.miss     = !hit;
		resp.invalid  = hit && !v;
		resp.modified = hit && v && req.wen && !d;
		resp.cached   = hit && (c == 3'd3);
		return resp;
	endfunction

	// Distinct kseg0 VPN2 per entry so nothing aliases after reset
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `TLB_ENTRIES; i++) begin
				entries[i]      <= '0;
				entries[i].vpn2 <= {3'b100, 16'(i)};
			end
		end else if (we_i) begin
			entries[widx_i] <= wentry_i;
		end
	end

	assign rentry_o = entries[ridx_i];

	always_comb begin
		probe_vec   = '0;
		probe_idx_o = '0;
		for (int i = 0; i < `TLB_ENTRIES; i++) begin
			probe_vec[i] = entry_match(entries[i], entryhi_i[31:13], entryhi_i[7:0]);
			if (probe_vec[i]) begin
				probe_idx_o = `TLB_IDX_W'(i);
			end
		end
	end

	assign probe_hit_o = probe_i && (|probe_vec);

	always_comb begin
		inst_resp_o = translate(inst_req_i, entryhi_i[7:0]);
		data_resp_o = translate(data_req_i, entryhi_i[7:0]);
	end

	// Software must never write overlapping entries
	a_probe_unique: assert property (@(posedge clk) disable iff (rst_i)
		probe_i |-> $onehot0(probe_vec));

endmodule

// ==== src/cp0_regs.sv ====
`timescale 1ns/1ns
`include "cp0_defines.svh"

module cp0_regs (
	input  logic                  clk,
	input  logic                  rst_i,
	input  cp0_pkg::cp0_wr_t      cp0_wr_i,
	input  logic [4:0]            raddr_i,
	output logic [31:0]           rdata_o,
	input  cp0_pkg::cp0_except_t  except_i,
	input  logic [5:0]            int_i,
	input  logic                  timer_int_i,
	input  logic [31:0]           count_i,
	input  logic [31:0]           compare_i,
	input  logic [`TLB_IDX_W-1:0] random_i,
	output cp0_pkg::cp0_wr_t      count_wr_o,
	input  logic                  upd_index_i,
	input  logic                  upd_entry_i,
	input  logic                  probe_hit_i,
	input  logic [`TLB_IDX_W-1:0] probe_idx_i,
	input  cp0_pkg::tlb_entry_t   rd_entry_i,
	output logic [`TLB_IDX_W-1:0] index_o,
	output logic [31:0]           entryhi_o,
	output cp0_pkg::tlb_entry_t   wr_entry_o,
	output logic                  int_pending_o
);

	logic                  index_p;
	logic [`TLB_IDX_W-1:0] index_idx;
	// EntryLo as {PFN, C, D, V, G}
	logic [25:0]           entrylo0;
	logic [25:0]           entrylo1;
	logic [18:0]           hi_vpn2;
	logic [7:0]            hi_asid;
	logic [31:0]           badvaddr;
	logic [31:0]           status;
	logic [31:0]           epc;
	logic                  cause_bd;
	logic                  cause_iv;
	logic [1:0]            cause_ip_sw;
	logic [4:0]            cause_exc;
	logic [7:0]            cause_ip;
	logic                  exc_commit;
	logic                  tlb_exc;
	logic                  addr_exc;

	assign exc_commit = except_i.valid && !except_i.eret;
	assign tlb_exc    = exc_commit && (except_i.exc_code == `EXC_MOD ||
		except_i.exc_code == `EXC_TLBL || except_i.exc_code == `EXC_TLBS);
	assign addr_exc   = tlb_exc || (exc_commit && (except_i.exc_code == `EXC_ADEL ||
		except_i.exc_code == `EXC_ADES));

	// Timer lives outside, pass its writes through
	always_comb begin
		count_wr_o    = cp0_wr_i;
		count_wr_o.we = cp0_wr_i.we && (cp0_wr_i.addr == `CP0_COUNT ||
			cp0_wr_i.addr == `CP0_COMPARE);
	end

	// TLB-side registers, TLB ops take priority over software
	always_ff @(posedge clk) begin
		if (rst_i) begin
			index_p   <= 1'b0;
			index_idx <= '0;
			entrylo0  <= '0;
			entrylo1  <= '0;
			hi_vpn2   <= '0;
			hi_asid   <= '0;
		end else begin
			if (upd_index_i) begin
				index_p <= !probe_hit_i;
				if (probe_hit_i) begin
					index_idx <= probe_idx_i;
				end
			end else if (cp0_wr_i.we && cp0_wr_i.addr == `CP0_INDEX) begin
				index_idx <= cp0_wr_i.data[`TLB_IDX_W-1:0];
			end
			if (upd_entry_i) begin
				hi_vpn2  <= rd_entry_i.vpn2;
				hi_asid  <= rd_entry_i.asid;
				entrylo0 <= {rd_entry_i.pfn0, rd_entry_i.c0, rd_entry_i.d0, rd_entry_i.v0,
					rd_entry_i.g};
				entrylo1 <= {rd_entry_i.pfn1, rd_entry_i.c1, rd_entry_i.d1, rd_entry_i.v1,
					rd_entry_i.g};
			end else if (cp0_wr_i.we) begin
				case (cp0_wr_i.addr)
					`CP0_ENTRYLO0: entrylo0 <= cp0_wr_i.data[25:0];
					`CP0_ENTRYLO1: entrylo1 <= cp0_wr_i.data[25:0];
					`CP0_ENTRYHI: begin
						hi_vpn2 <= cp0_wr_i.data[31:13];
						hi_asid <= cp0_wr_i.data[7:0];
					end
					default: begin
					end
				endcase
			end
			// Faulting page goes to EntryHi for the refill handler
			if (tlb_exc) begin
				hi_vpn2 <= except_i.badvaddr[31:13];
			end
		end
	end

	// Status, Cause, EPC and BadVAddr; exception assignments come last so they win
	always_ff @(posedge clk) begin
		if (rst_i) begin
			status      <= `STATUS_RESET;
			epc         <= '0;
			badvaddr    <= '0;
			cause_bd    <= 1'b0;
			cause_iv    <= 1'b0;
			cause_ip_sw <= '0;
			cause_exc   <= '0;
		end else begin
			if (cp0_wr_i.we) begin
				case (cp0_wr_i.addr)
					`CP0_STATUS: status <= cp0_wr_i.data;
					`CP0_EPC: epc <= cp0_wr_i.data;
					`CP0_CAUSE: begin
						cause_iv    <= cp0_wr_i.data[23];
						cause_ip_sw <= cp0_wr_i.data[9:8];
					end
					default: begin
					end
				endcase
			end
			if (exc_commit) begin
				// Nested exception keeps the first EPC and BD
				if (!status[1]) begin
					epc      <= except_i.in_delay_slot ? except_i.pc - 32'd4 : except_i.pc;
					cause_bd <= except_i.in_delay_slot;
				end
				cause_exc <= except_i.exc_code;
				status[1] <= 1'b1;
				if (addr_exc) begin
					badvaddr <= except_i.badvaddr;
				end
			end else if (except_i.valid) begin
				status[1] <= 1'b0;
			end
		end
	end

	// IP7 shared with the timer
	assign cause_ip = {int_i[5] | timer_int_i, int_i[4:0], cause_ip_sw};

	assign int_pending_o = status[0] && !status[1] && |(cause_ip & status[15:8]);

	always_comb begin
		case (raddr_i)
			`CP0_INDEX: rdata_o = {index_p, {(31 - `TLB_IDX_W){1'b0}}, index_idx};
			`CP0_RANDOM: rdata_o = {{(32 - `TLB_IDX_W){1'b0}}, random_i};
			`CP0_ENTRYLO0: rdata_o = {6'b0, entrylo0};
			`CP0_ENTRYLO1: rdata_o = {6'b0, entrylo1};
			`CP0_BADVADDR: rdata_o = badvaddr;
			`CP0_COUNT: rdata_o = count_i;
			`CP0_ENTRYHI: rdata_o = {hi_vpn2, 5'b0, hi_asid};
			`CP0_COMPARE: rdata_o = compare_i;
			`CP0_STATUS: rdata_o = status;
			`CP0_CAUSE: rdata_o = {cause_bd, 7'b0, cause_iv, 7'b0, cause_ip, 1'b0,
				cause_exc, 2'b0};
			`CP0_EPC: rdata_o = epc;
			`CP0_PRID: rdata_o = `PRID_VALUE;
			`CP0_CONFIG: rdata_o = `CONFIG_RESET;
			default: rdata_o = '0;
		endcase
	end

	assign index_o   = index_idx;
	assign entryhi_o = {hi_vpn2, 5'b0, hi_asid};

	// Global only when both halves agree
	always_comb begin
		wr_entry_o      = '0;
		wr_entry_o.vpn2 = hi_vpn2;
		wr_entry_o.asid = hi_asid;
		wr_entry_o.g    = entrylo0[0] & entrylo1[0];
		{wr_entry_o.pfn0, wr_entry_o.c0, wr_entry_o.d0, wr_entry_o.v0} = entrylo0[25:1];
		{wr_entry_o.pfn1, wr_entry_o.c1, wr_entry_o.d1, wr_entry_o.v1} = entrylo1[25:1];
	end

	// The timer must pick up a forwarded write on the next cycle
	a_count_fwd: assert property (@(posedge clk) disable iff (rst_i)
		(cp0_wr_i.we && cp0_wr_i.addr == `CP0_COUNT) |=> (count_i == $past(cp0_wr_i.data)));
	a_compare_fwd: assert property (@(posedge clk) disable iff (rst_i)
		(cp0_wr_i.we && cp0_wr_i.addr == `CP0_COMPARE) |=>
		(compare_i == $past(cp0_wr_i.data)));

endmodule

// ==== src/cp0_tlb_ctrl.sv ====
`timescale 1ns/1ns
`include "cp0_defines.svh"

module cp0_tlb_ctrl (
	input  logic                  clk,
	input  logic                  rst_i,
	input  cp0_pkg::tlb_op_e      tlb_op_i,
	input  logic [`TLB_IDX_W-1:0] index_i,
	input  logic [`TLB_IDX_W-1:0] random_i,
	output logic                  tlb_busy_o,
	output logic                  tlb_we_o,
	output logic [`TLB_IDX_W-1:0] tlb_widx_o,
	output logic [`TLB_IDX_W-1:0] tlb_ridx_o,
	output logic                  probe_o,
	output logic                  upd_index_o,
	output logic                  upd_entry_o
);

	typedef enum logic [1:0] {
		IDLE,
		PROBE,
		READ,
		WRITE
	} state_e;

	state_e state;
	logic [`TLB_IDX_W-1:0] op_idx;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					case (tlb_op_i)
						cp0_pkg::TLB_P: state <= PROBE;
						cp0_pkg::TLB_R: state <= READ;
						cp0_pkg::TLB_WI: state <= WRITE;
						cp0_pkg::TLB_WR: state <= WRITE;
						default: state <= IDLE;
					endcase
				end
				// Every operation finishes in its single busy cycle
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Slot is fixed at the pulse, Random for TLBWR and Index otherwise
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			if (tlb_op_i == cp0_pkg::TLB_WR) begin
				op_idx <= random_i;
			end else begin
				op_idx <= index_i;
			end
		end
	end

	assign tlb_busy_o  = (state != IDLE);
	assign tlb_we_o    = (state == WRITE);
	assign probe_o     = (state == PROBE);
	assign upd_index_o = (state == PROBE);
	assign upd_entry_o = (state == READ);
	assign tlb_widx_o  = op_idx;
	assign tlb_ridx_o  = op_idx;

	// Pipeline must hold off new TLB ops while busy
	a_no_op_while_busy: assert property (@(posedge clk) disable iff (rst_i)
		tlb_busy_o |-> (tlb_op_i == cp0_pkg::TLB_NONE));

endmodule

// ==== src/cp0_timer.sv ====
`timescale 1ns/1ns
`include "cp0_defines.svh"

module cp0_timer (
	input  logic                  clk,
	input  logic                  rst_i,
	input  cp0_pkg::cp0_wr_t      count_wr_i,
	output logic [31:0]           count_o,
	output logic [31:0]           compare_o,
	output logic [`TLB_IDX_W-1:0] random_o,
	output logic                  timer_int_o
);

	logic count_we;
	logic compare_we;

	assign count_we   = count_wr_i.we && (count_wr_i.addr == `CP0_COUNT);
	assign compare_we = count_wr_i.we && (count_wr_i.addr == `CP0_COMPARE);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			count_o     <= '0;
			compare_o   <= '0;
			timer_int_o <= 1'b0;
		end else begin
			// Written value holds one cycle, then counting resumes
			count_o <= count_we ? count_wr_i.data : count_o + 32'd1;
			if (compare_we) begin
				compare_o   <= count_wr_i.data;
				timer_int_o <= 1'b0;
			end else if (compare_o != '0 && count_o == compare_o) begin
				timer_int_o <= 1'b1;
			end
		end
	end

	// Random picks the TLBWR slot
	always_ff @(posedge clk) begin
		if (rst_i) begin
			random_o <= `TLB_IDX_W'(`TLB_ENTRIES - 1);
		end else if (random_o == '0) begin
			random_o <= `TLB_IDX_W'(`TLB_ENTRIES - 1);
		end else begin
			random_o <= random_o - 1'b1;
		end
	end

endmodule

// ==== src/cp0_pkg.sv ====
package cp0_pkg;

	// Software register write
	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
	} cp0_wr_t;

	// Committed exception or ERET from the pipeline
	typedef struct packed {
		logic        valid;
		logic        eret;
		logic [4:0]  exc_code;
		logic [31:0] pc;
		logic        in_delay_slot;
		logic [31:0] badvaddr;
	} cp0_except_t;

	// One TLB entry, even page (0) and odd page (1)
	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        g;
		logic [19:0] pfn0;
		logic [2:0]  c0;
		logic        d0;
		logic        v0;
		logic [19:0] pfn1;
		logic [2:0]  c1;
		logic        d1;
		logic        v1;
	} tlb_entry_t;

	typedef enum logic [2:0] {
		TLB_NONE,
		TLB_P,
		TLB_R,
		TLB_WI,
		TLB_WR
	} tlb_op_e;

	typedef struct packed {
		logic [31:0] vaddr;
		logic        ren;
		logic        wen;
	} xlat_req_t;

	typedef struct packed {
		logic [31:0] paddr;
		logic        miss;
		logic        invalid;
		logic        modified;
		logic        cached;
	} xlat_resp_t;

endpackage

// ==== src/cp0_defines.svh ====
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// CP0 register numbers, select 0 only
`define CP0_INDEX       5'd0
`define CP0_RANDOM      5'd1
`define CP0_ENTRYLO0    5'd2
`define CP0_ENTRYLO1    5'd3
`define CP0_BADVADDR    5'd8
`define CP0_COUNT       5'd9
`define CP0_ENTRYHI     5'd10
`define CP0_COMPARE     5'd11
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_PRID        5'd15
`define CP0_CONFIG      5'd16

// Cause.ExcCode values
`define EXC_INT         5'd0
`define EXC_MOD         5'd1
`define EXC_TLBL        5'd2
`define EXC_TLBS        5'd3
`define EXC_ADEL        5'd4
`define EXC_ADES        5'd5
`define EXC_SYS         5'd8
`define EXC_BP          5'd9
`define EXC_RI          5'd10
`define EXC_OV          5'd12

`define TLB_ENTRIES     16
`define TLB_IDX_W       4

// CU0 and BEV set
`define STATUS_RESET    32'h1040_0000
// Big endian
`define CONFIG_RESET    32'h0000_8000
`define PRID_VALUE      32'h0001_8021

`endif
